// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = cpuTb
FILELIST = src.f
LOG      = sim.log
SIMARGS  = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Done: no errors" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: src.f
verilog/rvIsaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/controlUnit.sv
verilog/immExtend.sv
verilog/alu.sv
verilog/regFile.sv
verilog/loadStore.sv
verilog/cpuTop.sv
verification/cpuTop_checker.sv
verification/cpuTb.sv

// File: verification/cpuTb.sv
module cpuTb;

    localparam int          resetCycles = 5;
    localparam logic [31:0] nopWord     = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [31:0] anyAddr     = 32'hFFFF_FFFF; // address not compared

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] dataAddr;
    logic [31:0] dataWrData;
    logic [3:0]  dataByteEn;
    logic        dataWe;
    logic [31:0] dataRdData;

    logic [31:0] dataMem [64];

    // trace table, one entry per executed instruction
    logic [31:0] tabPc [$];
    logic [31:0] tabInstr [$];
    logic        tabWe [$];
    logic [31:0] tabAddr [$];
    logic [31:0] tabData [$];
    logic [3:0]  tabBe [$];
    int          tabGroup [$];

    string groupName [6] = '{"arithmetic", "lui", "store lanes", "loads", "branches", "jumps"};
    int    curGroup;
    int    errorCount = 0;
    int    groupErrors = 0;
    int    passCount = 0;
    int    failCount = 0;
    int    cycleCount = 0;
    int    cycleLimit = 1000;

    cpuTop uut (
        .clk(clk), .rst(rst), .pc(pc), .instr(instr), .dataAddr(dataAddr),
        .dataWrData(dataWrData), .dataByteEn(dataByteEn), .dataWe(dataWe),
        .dataRdData(dataRdData)
    );

    always #20 clk = ~clk;

    assign dataRdData = dataMem[dataAddr[7:2]]; // async read, word addressed

    always @(posedge clk)
    begin
        if (dataWe)
        begin
            for (int k = 0; k < 4; k++)
            begin
                if (dataByteEn[k])
                begin
                    dataMem[dataAddr[7:2]][8*k +: 8] <= dataWrData[8*k +: 8];
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout: run still going after %0d cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // instruction encoders, register numbers and immediates as plain ints
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(input logic [2:0] f3, input int rs2, input int rs1,
                                         input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] encJ(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
    endfunction

    function automatic logic [31:0] laneMask(input logic [3:0] be);
        logic [31:0] mask;
        for (int k = 0; k < 4; k++)
        begin
            mask[8*k +: 8] = {8{be[k]}};
        end
        return mask;
    endfunction

    task automatic addRow(input logic [31:0] rowPc, input logic [31:0] word, input logic we,
                          input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] be);
        tabPc.push_back(rowPc);
        tabInstr.push_back(word);
        tabWe.push_back(we);
        tabAddr.push_back(addr);
        tabData.push_back(data);
        tabBe.push_back(be);
        tabGroup.push_back(curGroup);
    endtask

    task automatic addOp(input logic [31:0] rowPc, input logic [31:0] word);
        addRow(rowPc, word, 1'b0, anyAddr, 32'b0, 4'b0);
    endtask

    task automatic addLoad(input logic [31:0] rowPc, input logic [31:0] word,
                           input logic [31:0] addr);
        addRow(rowPc, word, 1'b0, addr, 32'b0, 4'b0);
    endtask

    task automatic addStore(input logic [31:0] rowPc, input logic [31:0] word,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
        addRow(rowPc, word, 1'b1, addr, data, be);
    endtask

    task automatic buildTable();
        curGroup = 0;
        addOp('h00, encI(7'h13, 3'h0, 1, 0, 5));                   // addi x1, x0, 5
        addOp('h04, encI(7'h13, 3'h0, 2, 0, -3));                  // addi x2, x0, -3
        addOp('h08, encR(7'h00, 3'h0, 3, 1, 2));                   // add x3 = 2
        addOp('h0C, encR(7'h20, 3'h0, 4, 2, 1));                   // sub x4 = -8
        addOp('h10, encR(7'h20, 3'h5, 5, 4, 3));                   // sra x5 = -2
        addStore('h14, encS(3'h2, 5, 0, 'h80), 'h80, 32'hFFFF_FFFE, 4'hF);
        addOp('h18, encR(7'h00, 3'h2, 6, 2, 1));                   // slt -3 < 5
        addOp('h1C, encR(7'h00, 3'h3, 7, 2, 1));                   // sltu, 0xfffffffd not < 5
        addStore('h20, encS(3'h2, 6, 0, 'h84), 'h84, 32'h0000_0001, 4'hF);
        addStore('h24, encS(3'h2, 7, 0, 'h88), 'h88, 32'h0000_0000, 4'hF);
        addOp('h28, encI(7'h13, 3'h4, 8, 2, 'hF0));                // xori x8 = ffffff0d
        addOp('h2C, encI(7'h13, 3'h5, 9, 8, 'h404));               // srai x9, x8, 4
        addStore('h30, encS(3'h2, 9, 0, 'h8C), 'h8C, 32'hFFFF_FFF0, 4'hF);
        addOp('h34, encI(7'h13, 3'h6, 10, 3, 'h100));              // ori x10 = 0x102
        addOp('h38, encR(7'h00, 3'h7, 11, 10, 4));                 // and x11 = 0x100
        addOp('h3C, encR(7'h00, 3'h1, 12, 11, 3));                 // sll x12 = 0x400
        addStore('h40, encS(3'h2, 12, 0, 'h90), 'h90, 32'h0000_0400, 4'hF);
        curGroup = 1;
        addOp('h44, encU(13, 'hDEADC));                            // lui x13
        addOp('h48, encI(7'h13, 3'h0, 13, 13, -273));              // x13 = deadbeef
        addStore('h4C, encS(3'h2, 13, 0, 'h94), 'h94, 32'hDEAD_BEEF, 4'hF);
        curGroup = 2;
        addStore('h50, encS(3'h0, 13, 0, 'hC1), 'hC1, 32'h0000_EF00, 4'b0010);
        addStore('h54, encS(3'h0, 13, 0, 'hC3), 'hC3, 32'hEF00_0000, 4'b1000);
        addStore('h58, encS(3'h0, 13, 0, 'hC0), 'hC0, 32'h0000_00EF, 4'b0001);
        addStore('h5C, encS(3'h0, 13, 0, 'hC2), 'hC2, 32'h00EF_0000, 4'b0100);
        addStore('h60, encS(3'h1, 13, 0, 'hC6), 'hC6, 32'hBEEF_0000, 4'b1100);
        addStore('h64, encS(3'h1, 13, 0, 'hC4), 'hC4, 32'h0000_BEEF, 4'b0011);
        addLoad('h68, encI(7'h03, 3'h2, 14, 0, 'hC4), 'hC4);       // lw, both halves merged
        addStore('h6C, encS(3'h2, 14, 0, 'h98), 'h98, 32'hBEEF_BEEF, 4'hF);
        curGroup = 3;
        addLoad('h70, encI(7'h03, 3'h0, 15, 0, 'hE0), 'hE0);       // lb
        addStore('h74, encS(3'h2, 15, 0, 'h9C), 'h9C, 32'hFFFF_FF85, 4'hF);
        addLoad('h78, encI(7'h03, 3'h4, 16, 0, 'hE0), 'hE0);       // lbu
        addStore('h7C, encS(3'h2, 16, 0, 'hA0), 'hA0, 32'h0000_0085, 4'hF);
        addLoad('h80, encI(7'h03, 3'h1, 17, 0, 'hE2), 'hE2);       // lh, upper half
        addStore('h84, encS(3'h2, 17, 0, 'hA4), 'hA4, 32'hFFFF_80F1, 4'hF);
        addLoad('h88, encI(7'h03, 3'h5, 18, 0, 'hE2), 'hE2);       // lhu
        addStore('h8C, encS(3'h2, 18, 0, 'hA8), 'hA8, 32'h0000_80F1, 4'hF);
        addLoad('h90, encI(7'h03, 3'h2, 19, 0, 'hE0), 'hE0);       // lw
        addStore('h94, encS(3'h2, 19, 0, 'hAC), 'hAC, 32'h80F1_7F85, 4'hF);
        curGroup = 4;
        addOp('h98, encB(3'h0, 1, 1, 8));                          // beq taken
        addOp('hA0, encB(3'h0, 1, 3, 8));                          // beq falls through
        addOp('hA4, encB(3'h1, 1, 3, 8));                          // bne taken
        addOp('hAC, encB(3'h1, 1, 1, 8));
        addOp('hB0, encB(3'h4, 2, 1, 8));                          // blt -3 < 5 taken
        addOp('hB8, encB(3'h4, 1, 2, 8));
        addOp('hBC, encB(3'h5, 1, 2, 8));                          // bge taken
        addOp('hC4, encB(3'h5, 2, 1, 8));
        addOp('hC8, encB(3'h6, 1, 2, 8));                          // bltu taken
        addOp('hD0, encB(3'h6, 2, 1, 8));
        addOp('hD4, encB(3'h7, 2, 1, 8));                          // bgeu taken
        addOp('hDC, encB(3'h7, 1, 2, 8));
        curGroup = 5;
        addOp('hE0, encJ(20, 12));                                 // jal x20, +12
        addStore('hEC, encS(3'h2, 20, 0, 'hB0), 'hB0, 32'h0000_00E4, 4'hF);
        addOp('hF0, encI(7'h13, 3'h0, 21, 0, 'h171));              // odd base for jalr
        addOp('hF4, encI(7'h67, 3'h0, 22, 21, 'h10));              // jalr, bit 0 cleared
        addStore('h180, encS(3'h2, 22, 0, 'hB4), 'hB4, 32'h0000_00F8, 4'hF);
        addOp('h184, encJ(23, -'h84));                             // jal backwards
        addStore('h100, encS(3'h2, 23, 0, 'hB8), 'hB8, 32'h0000_0188, 4'hF);
    endtask

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("error: time %0t, %s is %h, expected %h", $time, name, got, exp);
        errorCount++;
        groupErrors++;
    endtask

    task automatic runRow(input int n);
        logic [31:0] mask;
        if (pc !== tabPc[n])
        begin
            reportValue("pc", pc, tabPc[n]);
        end
        instr = tabInstr[n];
        #1; // let the combinational path settle
        mask = laneMask(tabBe[n]);
        if (dataWe !== tabWe[n])
        begin
            reportValue("dataWe", {31'b0, dataWe}, {31'b0, tabWe[n]});
        end
        if (dataByteEn !== tabBe[n])
        begin
            reportValue("dataByteEn", {28'b0, dataByteEn}, {28'b0, tabBe[n]});
        end
        if (tabAddr[n] != anyAddr && dataAddr !== tabAddr[n])
        begin
            reportValue("dataAddr", dataAddr, tabAddr[n]);
        end
        if ((dataWrData & mask) !== (tabData[n] & mask))
        begin
            reportValue("dataWrData", dataWrData & mask, tabData[n] & mask);
        end
    endtask

    task automatic finishGroup(input int g);
        if (groupErrors == 0)
        begin
            passCount++;
            $display("test %s: pass", groupName[g]);
        end
        else
        begin
            failCount++;
            $display("test %s: fail with %0d errors", groupName[g], groupErrors);
        end
        groupErrors = 0;
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        instr = nopWord; // pc 0 sees a nop for the whole reset
        void'($urandom(33804));
        for (int w = 0; w < 64; w++)
        begin
            dataMem[w[5:0]] = $urandom();
        end
        dataMem[56] = 32'h80F1_7F85; // word at 0xe0 for the loads
        buildTable();
        cycleLimit = tabPc.size() + resetCycles + 20;

        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < tabPc.size(); n++)
        begin
            if (n > 0)
            begin
                @(negedge clk);
            end
            runRow(n);
            if (n == tabPc.size() - 1 || tabGroup[n + 1] != tabGroup[n])
            begin
                finishGroup(tabGroup[n]);
            end
        end
        @(negedge clk);
        instr = nopWord;

        if (uut.chk.assertFails != 0)
        begin
            $display("checker reported %0d assertion failures", uut.chk.assertFails);
            errorCount += uut.chk.assertFails;
        end
        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
        if (errorCount == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verification/cpuTop_checker.sv
module cpuTopChecker (
    input logic        clk,
    input logic        rst,
    input logic [31:0] pc,
    input logic        dataWe,
    input logic [3:0]  dataByteEn
);

    int assertFails = 0; // read by the testbench at the end

    pcZeroAfterReset: assert property (@(posedge clk) rst |=> pc == 32'b0)
    else
    begin
        $error("pc not zero in the cycle after reset");
        assertFails++;
    end

    // core sees a nop during reset
    quietInReset: assert property (@(posedge clk) rst |-> !dataWe && dataByteEn == 4'b0)
    else
    begin
        $error("data write active during reset");
        assertFails++;
    end

    enablesMatchWrite: assert property (@(posedge clk) disable iff (rst)
                                        (dataByteEn != 4'b0) == dataWe)
    else
    begin
        $error("byte enables and dataWe disagree");
        assertFails++;
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else
    begin
        $error("pc not word aligned");
        assertFails++;
    end

endmodule

bind cpuTop cpuTopChecker chk (.*);

// File: verilog/alu.sv
module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [3:0]  aluCtrl,
    output logic [31:0] result,
    output logic        zero
);
    import cpuCtrlPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (aluCtrl)
            aluAdd:
                result = a + b;
            aluSub:
                result = a - b;
            aluSll:
                result = a << shamt;
            aluSlt:
                result = {31'b0, $signed(a) < $signed(b)};
            aluSltu:
                result = {31'b0, a < b};
            aluXor:
                result = a ^ b;
            aluSrl:
                result = a >> shamt;
            aluSra:
                result = $unsigned($signed(a) >>> shamt); // keeps sign bit
            aluOr:
                result = a | b;
            aluAnd:
                result = a & b;
            aluPassB:
                result = b;
            default:
                result = 32'b0;
        endcase
    end

    assign zero = (result == 32'b0); // beq/bne after sub

endmodule

// File: verilog/controlUnit.sv
module controlUnit (
    input  rvIsaPkg::instrWord instr,
    output logic               regWrite,
    output logic               memWrite,
    output logic               aluSrc,
    output logic               branch,
    output logic               jump,
    output logic               jalr,
    output logic [1:0]         resultSrc,
    output logic [2:0]         immSrc,
    output logic [3:0]         aluCtrl,
    output logic [2:0]         dataWidth
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    logic [2:0] memWidth;  // funct3 mapped for loads and stores
    logic [3:0] branchAlu; // compare op for branches
    logic [3:0] immAlu;    // op for I-type arithmetic

    always_comb
    begin
        case (instr.r.funct3)
            f3Byte:  memWidth = widthByte;
            f3Half:  memWidth = widthHalf;
            f3Word:  memWidth = widthWord;
            f3ByteU: memWidth = widthByteU;
            f3HalfU: memWidth = widthHalfU;
            default: memWidth = widthWord;
        endcase
    end

    always_comb
    begin
        case (instr.r.funct3)
            f3Beq, f3Bne:   branchAlu = aluSub;  // equality via zero flag
            f3Blt, f3Bge:   branchAlu = aluSlt;
            f3Bltu, f3Bgeu: branchAlu = aluSltu;
            default:        branchAlu = aluSub;
        endcase
    end

    // funct7[5] only distinguishes srai from srli
    assign immAlu = {(instr.r.funct3 == aluSrl[2:0]) & instr.r.funct7[5], instr.r.funct3};

    always_comb
    begin
        case (instr.r.opcode)
            opR:
            begin
                {regWrite, memWrite, aluSrc} = 3'b100;
                {branch, jump, jalr} = 3'b000;
                resultSrc = resAlu;
                immSrc = immI; // unused
                aluCtrl = {instr.r.funct7[5], instr.r.funct3};
                dataWidth = widthWord;
            end
            opImm:
            begin
                {regWrite, memWrite, aluSrc} = 3'b101;
                {branch, jump, jalr} = 3'b000;
                resultSrc = resAlu;
                immSrc = immI;
                aluCtrl = immAlu;
                dataWidth = widthWord;
            end
            opLoad:
            begin
                {regWrite, memWrite, aluSrc} = 3'b101;
                {branch, jump, jalr} = 3'b000;
                resultSrc = resMem;
                immSrc = immI;
                aluCtrl = aluAdd; // base plus offset
                dataWidth = memWidth;
            end
            opStore:
            begin
                {regWrite, memWrite, aluSrc} = 3'b011;
                {branch, jump, jalr} = 3'b000;
                resultSrc = resAlu;
                immSrc = immS;
                aluCtrl = aluAdd;
                dataWidth = memWidth;
            end
            opBranch:
            begin
                {regWrite, memWrite, aluSrc} = 3'b000;
                {branch, jump, jalr} = 3'b100;
                resultSrc = resAlu;
                immSrc = immB;
                aluCtrl = branchAlu;
                dataWidth = widthWord;
            end
            opLui:
            begin
                {regWrite, memWrite, aluSrc} = 3'b101;
                {branch, jump, jalr} = 3'b000;
                resultSrc = resAlu;
                immSrc = immU;
                aluCtrl = aluPassB;
                dataWidth = widthWord;
            end
            opJal:
            begin
                {regWrite, memWrite, aluSrc} = 3'b101;
                {branch, jump, jalr} = 3'b010;
                resultSrc = resPcPlus4;
                immSrc = immJ;
                aluCtrl = aluAdd; // result unused
                dataWidth = widthWord;
            end
            opJalr:
            begin
                {regWrite, memWrite, aluSrc} = 3'b101;
                {branch, jump, jalr} = 3'b011;
                resultSrc = resPcPlus4;
                immSrc = immI;
                aluCtrl = aluAdd; // rs1 + offset is the target
                dataWidth = widthWord;
            end
            default:
            begin
                {regWrite, memWrite, aluSrc} = 3'b000; // behaves as a nop
                {branch, jump, jalr} = 3'b000;
                resultSrc = resAlu;
                immSrc = immI;
                aluCtrl = aluAdd;
                dataWidth = widthWord;
            end
        endcase
    end

endmodule

// File: verilog/cpuCtrlPkg.sv
package cpuCtrlPkg;

    // alu op codes, funct7[5] packed above funct3
    localparam logic [3:0] aluAdd   = 4'b0000;
    localparam logic [3:0] aluSub   = 4'b1000;
    localparam logic [3:0] aluSll   = 4'b0001;
    localparam logic [3:0] aluSlt   = 4'b0010;
    localparam logic [3:0] aluSltu  = 4'b0011;
    localparam logic [3:0] aluXor   = 4'b0100;
    localparam logic [3:0] aluSrl   = 4'b0101;
    localparam logic [3:0] aluSra   = 4'b1101;
    localparam logic [3:0] aluOr    = 4'b0110;
    localparam logic [3:0] aluAnd   = 4'b0111;
    localparam logic [3:0] aluPassB = 4'b1001; // lui

    // write-back source
    localparam logic [1:0] resAlu     = 2'b00;
    localparam logic [1:0] resMem     = 2'b01;
    localparam logic [1:0] resPcPlus4 = 2'b10;

    // immediate formats
    localparam logic [2:0] immI = 3'b000;
    localparam logic [2:0] immS = 3'b001;
    localparam logic [2:0] immB = 3'b010;
    localparam logic [2:0] immJ = 3'b011;
    localparam logic [2:0] immU = 3'b100;

    // data width: [1:0] size, [2] unsigned load
    localparam logic [2:0] widthWord  = 3'b000;
    localparam logic [2:0] widthHalf  = 3'b001;
    localparam logic [2:0] widthByte  = 3'b010;
    localparam logic [2:0] widthHalfU = 3'b101;
    localparam logic [2:0] widthByteU = 3'b110;

endpackage

// File: verilog/cpuTop.sv
module cpuTop (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWrData,
    output logic [3:0]  dataByteEn,
    output logic        dataWe,
    input  logic [31:0] dataRdData
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    instrWord    instrView;
    logic        regWrite;
    logic        memWrite;
    logic        aluSrc;
    logic        branch;
    logic        jump;
    logic        jalr;
    logic [1:0]  resultSrc;
    logic [2:0]  immSrc;
    logic [3:0]  aluCtrl;
    logic [2:0]  dataWidth;
    logic [31:0] imm;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic        zero;
    logic [31:0] loadValue;
    logic [31:0] result;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] pcNext;
    logic        condRaw;
    logic        taken;

    assign instrView = instr;

    controlUnit ctrl (
        .instr(instrView), .regWrite(regWrite), .memWrite(memWrite), .aluSrc(aluSrc),
        .branch(branch), .jump(jump), .jalr(jalr), .resultSrc(resultSrc),
        .immSrc(immSrc), .aluCtrl(aluCtrl), .dataWidth(dataWidth)
    );

    immExtend immGen (.instr(instrView), .immSrc(immSrc), .imm(imm));

    regFile regs (
        .clk(clk), .we(regWrite), .ra1(instrView.r.rs1), .ra2(instrView.r.rs2),
        .wa(instrView.r.rd), .wd(result), .rd1(rs1Data), .rd2(rs2Data)
    );

    assign srcB = aluSrc ? imm : rs2Data;

    alu aluUnit (.a(rs1Data), .b(srcB), .aluCtrl(aluCtrl), .result(aluResult), .zero(zero));

    loadStore lsu (
        .addrLow(aluResult[1:0]), .storeValue(rs2Data), .memWrite(memWrite),
        .dataWidth(dataWidth), .dataRdData(dataRdData), .dataWrData(dataWrData),
        .dataByteEn(dataByteEn), .dataWe(dataWe), .loadValue(loadValue)
    );

    assign dataAddr = aluResult;

    // funct3[2] picks ordered compare over equality, funct3[0] inverts
    assign condRaw = instrView.b.funct3[2] ? aluResult[0] : zero;
    assign taken = jump | (branch & (condRaw ^ instrView.b.funct3[0]));

    assign pcPlus4 = pc + 32'd4;
    assign pcTarget = pc + imm;
    assign pcNext = jalr  ? {aluResult[31:1], 1'b0} :
                    taken ? pcTarget : pcPlus4;

    always_comb
    begin
        case (resultSrc)
            resMem:     result = loadValue;
            resPcPlus4: result = pcPlus4; // link address
            default:    result = aluResult;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= 32'b0;
        end
        else
        begin
            pc <= pcNext;
        end
    end

endmodule

// File: verilog/immExtend.sv
module immExtend (
    input  rvIsaPkg::instrWord instr,
    input  logic [2:0]         immSrc,
    output logic [31:0]        imm
);
    import cpuCtrlPkg::*;

    always_comb
    begin
        case (immSrc)
            immI:
                imm = {{20{instr.i.imm11to0[11]}}, instr.i.imm11to0};
            immS:
                imm = {{20{instr.s.imm11to5[6]}}, instr.s.imm11to5, instr.s.imm4to0};
            immB:
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0}; // always even
            immJ:
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                       instr.j.imm11, instr.j.imm10to1, 1'b0};
            immU:
                imm = {instr.u.imm31to12, 12'b0}; // upper 20 bits, no extension
            default:
                imm = 32'b0;
        endcase
    end

endmodule

// File: verilog/loadStore.sv
module loadStore (
    input  logic [1:0]  addrLow,
    input  logic [31:0] storeValue,
    input  logic        memWrite,
    input  logic [2:0]  dataWidth,
    input  logic [31:0] dataRdData,
    output logic [31:0] dataWrData,
    output logic [3:0]  dataByteEn,
    output logic        dataWe,
    output logic [31:0] loadValue
);
    import cpuCtrlPkg::*;

    logic [3:0]  laneMask;  // byte enables before write gating
    logic [31:0] rdShifted; // addressed data moved down to lane 0
    logic        isUnsigned;

    assign isUnsigned = dataWidth[2];

    always_comb
    begin
        case (dataWidth[1:0])
            widthByte[1:0]:
            begin
                dataWrData = {4{storeValue[7:0]}}; // byte in every lane
                laneMask = 4'b0001 << addrLow;
            end
            widthHalf[1:0]:
            begin
                dataWrData = {2{storeValue[15:0]}};
                laneMask = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                dataWrData = storeValue;
                laneMask = 4'b1111;
            end
        endcase
    end

    assign dataByteEn = memWrite ? laneMask : 4'b0000;
    assign dataWe = memWrite;

    assign rdShifted = dataRdData >> {addrLow, 3'b000};

    always_comb
    begin
        case (dataWidth[1:0])
            widthByte[1:0]:
                loadValue = {{24{rdShifted[7] & ~isUnsigned}}, rdShifted[7:0]};
            widthHalf[1:0]:
                loadValue = {{16{rdShifted[15] & ~isUnsigned}}, rdShifted[15:0]};
            default:
                loadValue = dataRdData; // lw
        endcase
    end

endmodule

// File: verilog/regFile.sv
module regFile (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (we && (wa != 5'd0))
        begin
            regs[wa] <= wd;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rd1 = (ra1 == 5'd0) ? 32'b0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'b0 : regs[ra2];

endmodule

// File: verilog/rvIsaPkg.sv
package rvIsaPkg;

    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opJal    = 7'b1101111;

    // load and store widths
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

    // branch conditions
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // one instruction word, six ways to read it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm11to0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4to0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31to12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instrWord;

endpackage
